//--- Makefile
# Verilator build and run of the life display testbench
# override on the command line, e.g. make sim SEED=7 LOG=run7.log

VERILATOR ?= verilator
TOP       ?= tb_life_display
SEED      ?= 26249
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GRAND_SEED=$(SEED) \
		--Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/cell_buffer.sv
// display copy of the world, written by the engine, read by the pixel fetch
// read data appears one cycle after the address; off-grid reads return dead
`timescale 1ns/1ps

module cell_buffer (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  logic               we,        // engine write strobe
    input  life_pkg::cell_wr_t wr,
    input  life_pkg::cell_x_t  rd_x,
    input  life_pkg::cell_y_t  rd_y,
    output logic               rd_alive   // registered
);

    logic [life_pkg::GRID_CELLS-1:0] cells;
    int                              wr_idx;
    int                              rd_idx;

    assign wr_idx = int'(wr.y) * life_pkg::GRID_W + int'(wr.x);
    assign rd_idx = int'(rd_y) * life_pkg::GRID_W + int'(rd_x);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            cells <= life_pkg::SEED;  // matches engine world after reset
        end else if (we) begin
            cells[wr_idx] <= wr.alive;
        end
    end

    // rows past GRID_H are only addressed in blanking
    always_ff @(posedge clk_pix) begin
        rd_alive <= (rd_idx < life_pkg::GRID_CELLS) ? cells[rd_idx] : 1'b0;
    end

endmodule

//--- hw/display_timing.sv
// raster timing for the small test mode, counters start at 0,0 after reset
// sx/sy and every decoded output come from the same flops, so they line up
`timescale 1ns/1ps

module display_timing (
    input  logic             clk_pix,
    input  logic             rst_n,
    output life_pkg::coord_t sx,     // current pixel column
    output life_pkg::coord_t sy,     // current line
    output logic             hsync,  // active low
    output logic             vsync,  // active low
    output logic             de,     // active video
    output logic             line,   // first pixel of every line
    output logic             frame   // first pixel of line after active area
);

    life_pkg::coord_t x_nxt;  // position for the next cycle
    life_pkg::coord_t y_nxt;

    always_comb begin
        x_nxt = sx + 16'sd1;
        y_nxt = sy;
        if (sx == life_pkg::coord_t'(life_pkg::H_TOTAL - 1)) begin  // end of line
            x_nxt = '0;
            if (sy == life_pkg::coord_t'(life_pkg::V_TOTAL - 1)) begin
                y_nxt = '0;  // end of frame
            end else begin
                y_nxt = sy + 16'sd1;
            end
        end
    end

    // outputs decoded from next position, so registered alongside sx/sy
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx    <= life_pkg::coord_t'(life_pkg::H_TOTAL - 1);  // parked on last pixel
            sy    <= life_pkg::coord_t'(life_pkg::V_TOTAL - 1);  // so 0,0 comes next
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            line  <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= x_nxt;
            sy    <= y_nxt;
            hsync <= !(x_nxt >= life_pkg::H_ACTIVE + life_pkg::H_FP &&
                       x_nxt <  life_pkg::H_ACTIVE + life_pkg::H_FP + life_pkg::H_SYNC);
            vsync <= !(y_nxt >= life_pkg::V_ACTIVE + life_pkg::V_FP &&
                       y_nxt <  life_pkg::V_ACTIVE + life_pkg::V_FP + life_pkg::V_SYNC);
            de    <= x_nxt < life_pkg::H_ACTIVE && y_nxt < life_pkg::V_ACTIVE;
            line  <= x_nxt == 0;
            frame <= x_nxt == 0 && y_nxt == life_pkg::V_ACTIVE;  // start of vblank
        end
    end

endmodule

//--- hw/life_display.sv
// life display top: timing, engine, cell buffer and pixel fetch on one clock
// a generation starts in vblank after every GEN_FRAMES frames with run high
`timescale 1ns/1ps

module life_display (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  logic               run,      // level, pauses pacing when low
    output logic               hsync,
    output logic               vsync,
    output logic               de,
    output life_pkg::chan_t    red,
    output life_pkg::chan_t    green,
    output life_pkg::chan_t    blue,
    output logic               cell_we,
    output life_pkg::cell_wr_t cell_wr,
    output logic               done
);

    life_pkg::coord_t  sx;
    life_pkg::coord_t  sy;
    logic              hsync_t;  // timing outputs before the fetch stage
    logic              vsync_t;
    logic              de_t;
    logic              frame;
    logic              start;
    life_pkg::cell_x_t rd_x;
    life_pkg::cell_y_t rd_y;
    logic              rd_alive;
    logic [$clog2(life_pkg::GEN_FRAMES)-1:0] frame_cnt;  // counted frames with run

    // start one cycle after the frame pulse that completes the count
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
            start     <= 1'b0;
        end else begin
            start <= 1'b0;
            if (frame && run) begin  // holds while run is low
                if (int'(frame_cnt) == life_pkg::GEN_FRAMES - 1) begin
                    frame_cnt <= '0;
                    start     <= 1'b1;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    display_timing display_timing_i (
        .clk_pix, .rst_n, .sx, .sy,
        .hsync(hsync_t), .vsync(vsync_t), .de(de_t),
        .line(),  // no per-line work here
        .frame
    );

    life_engine life_engine_i (
        .clk_pix, .rst_n, .start, .cell_we, .cell_wr, .done,
        .running()  // busy starts are dropped inside the engine
    );

    cell_buffer cell_buffer_i (
        .clk_pix, .rst_n, .we(cell_we), .wr(cell_wr), .rd_x, .rd_y, .rd_alive
    );

    pixel_fetch pixel_fetch_i (
        .clk_pix, .rst_n, .sx, .sy,
        .hsync_in(hsync_t), .vsync_in(vsync_t), .de_in(de_t),
        .rd_x, .rd_y, .rd_alive,
        .hsync, .vsync, .de, .red, .green, .blue
    );

endmodule

//--- hw/life_engine.sv
// one life generation per start, one cell per clock in raster order
// cells off the grid are dead, world does not wrap; start while busy is dropped
// current world reloads SEED on reset
`timescale 1ns/1ps

module life_engine (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  logic               start,    // one-cycle request
    output logic               cell_we,  // new cell state valid
    output life_pkg::cell_wr_t cell_wr,
    output logic               done,     // one cycle after last cell
    output logic               running
);

    logic [life_pkg::GRID_CELLS-1:0] cur;  // world being read
    logic [life_pkg::GRID_CELLS-1:0] nxt;  // world being built
    life_pkg::cell_x_t   cx;               // cell under work
    life_pkg::cell_y_t   cy;
    life_pkg::cell_idx_t idx;
    logic [3:0]          n_cnt;            // live neighbours, 0..8
    logic                self_alive;
    logic                new_alive;
    logic                last_col;
    logic                last_cell;

    // dead outside the grid
    function automatic logic cell_at(input logic [life_pkg::GRID_CELLS-1:0] w,
                                     input int x, input int y);
        if (x < 0 || x >= life_pkg::GRID_W || y < 0 || y >= life_pkg::GRID_H) begin
            return 1'b0;
        end
        return w[y * life_pkg::GRID_W + x];
    endfunction

    assign idx        = life_pkg::cell_idx_t'(int'(cy) * life_pkg::GRID_W + int'(cx));
    assign self_alive = cur[idx];
    assign last_col   = cx == life_pkg::cell_x_t'(life_pkg::GRID_W - 1);
    assign last_cell  = last_col && cy == life_pkg::cell_y_t'(life_pkg::GRID_H - 1);

    always_comb begin
        n_cnt = '0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                if (dx != 0 || dy != 0) begin  // skip the cell itself
                    n_cnt = n_cnt + {3'b000, cell_at(cur, int'(cx) + dx, int'(cy) + dy)};
                end
            end
        end
    end

    // survive on 2 or 3, birth on exactly 3
    assign new_alive = self_alive ? (n_cnt == 4'd2 || n_cnt == 4'd3) : (n_cnt == 4'd3);

    assign cell_we = running;  // first strobe the cycle after start
    assign cell_wr = '{x: cx, y: cy, alive: new_alive};

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            done    <= 1'b0;
            cx      <= '0;
            cy      <= '0;
        end else begin
            done <= 1'b0;
            if (running) begin
                if (last_cell) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                    cx      <= '0;
                    cy      <= '0;
                end else if (last_col) begin
                    cx <= '0;
                    cy <= cy + 1'b1;
                end else begin
                    cx <= cx + 1'b1;
                end
            end else if (start) begin
                running <= 1'b1;  // cx, cy already at 0 when idle
            end
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            cur <= life_pkg::SEED;
        end else if (done) begin
            cur <= nxt;  // swap during the done cycle
        end
    end

    // fully rewritten each generation before it is used
    always_ff @(posedge clk_pix) begin
        if (running) begin
            nxt[idx] <= new_alive;
        end
    end

endmodule

//--- hw/life_pkg.sv
// sizes, seed, colours and cell types for the life display
// raster is tiny and only meant for simulation, not a real monitor mode
// grid index is y * GRID_W + x everywhere
package life_pkg;

    // raster timing in pixel clocks and lines
    localparam int H_ACTIVE = 32;
    localparam int H_FP     = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BP     = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 40 per line
    localparam int V_ACTIVE = 24;
    localparam int V_FP     = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 3;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 30 per frame

    localparam int GRID_W     = 16;               // cells across
    localparam int GRID_H     = 12;               // cells down
    localparam int GRID_CELLS = GRID_W * GRID_H;  // 192
    localparam int CELL_SCALE = 2;                // pixels per cell edge
    localparam int GEN_FRAMES = 3;                // frames of run per generation

    typedef logic signed [15:0] coord_t;   // screen coordinate
    typedef logic [3:0]         cell_x_t;  // cell column
    typedef logic [3:0]         cell_y_t;  // cell row
    typedef logic [7:0]         cell_idx_t;  // flat cell index
    typedef logic [3:0]         chan_t;    // one colour channel
    typedef logic [11:0]        rgb_t;     // r, g, b nibbles

    typedef struct packed {
        cell_x_t x;
        cell_y_t y;
        logic    alive;  // new state of cell x,y
    } cell_wr_t;

    // glider in the top left corner, blinker in the middle
    localparam logic [GRID_CELLS-1:0] SEED =
        (192'd1 << (0 * GRID_W + 1))  | (192'd1 << (1 * GRID_W + 2))  |
        (192'd1 << (2 * GRID_W + 0))  | (192'd1 << (2 * GRID_W + 1))  |
        (192'd1 << (2 * GRID_W + 2))  | (192'd1 << (5 * GRID_W + 10)) |
        (192'd1 << (5 * GRID_W + 11)) | (192'd1 << (5 * GRID_W + 12));

    localparam rgb_t ALIVE_RGB = 12'hFC2;  // yellow
    localparam rgb_t DEAD_RGB  = 12'h124;  // dark blue

endpackage

//--- hw/pixel_fetch.sv
// turns screen position into a cell read and a colour
// all outputs lag the timing inputs by one cycle, matching the buffer read
`timescale 1ns/1ps

module pixel_fetch (
    input  logic              clk_pix,
    input  logic              rst_n,
    input  life_pkg::coord_t  sx,
    input  life_pkg::coord_t  sy,
    input  logic              hsync_in,
    input  logic              vsync_in,
    input  logic              de_in,
    output life_pkg::cell_x_t rd_x,      // cell address to buffer
    output life_pkg::cell_y_t rd_y,
    input  logic              rd_alive,  // one cycle after rd_x/rd_y
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output life_pkg::chan_t   red,
    output life_pkg::chan_t   green,
    output life_pkg::chan_t   blue
);

    life_pkg::coord_t cell_sx;  // screen position in cells
    life_pkg::coord_t cell_sy;
    life_pkg::rgb_t   rgb;

    assign cell_sx = sx / life_pkg::coord_t'(life_pkg::CELL_SCALE);
    assign cell_sy = sy / life_pkg::coord_t'(life_pkg::CELL_SCALE);
    assign rd_x    = life_pkg::cell_x_t'(cell_sx);  // wraps in hblank, colour masked
    assign rd_y    = life_pkg::cell_y_t'(cell_sy);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
        end else begin
            hsync <= hsync_in;  // one stage to match the read
            vsync <= vsync_in;
            de    <= de_in;
        end
    end

    always_comb begin
        rgb = rd_alive ? life_pkg::ALIVE_RGB : life_pkg::DEAD_RGB;
        if (!de) begin
            rgb = '0;  // black in blanking
        end
    end

    assign {red, green, blue} = rgb;

endmodule

//--- tb.f
hw/life_pkg.sv
hw/display_timing.sv
hw/life_engine.sv
hw/cell_buffer.sv
hw/pixel_fetch.sv
hw/life_display.sv
testbench/life_checker.sv
testbench/life_display_props.sv
testbench/tb_life_display.sv

//--- testbench/life_checker.sv
// watches the life_display ports and checks them against its own world model
// pixel position is rebuilt from the delayed de, hsync and vsync outputs
`timescale 1ns/1ps

module life_checker (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  logic               run,
    input  logic               hsync,
    input  logic               vsync,
    input  logic               de,
    input  life_pkg::chan_t    red,
    input  life_pkg::chan_t    green,
    input  life_pkg::chan_t    blue,
    input  logic               cell_we,
    input  life_pkg::cell_wr_t cell_wr,
    input  logic               done,
    output int                 errors,  // wrong values seen
    output int                 gens     // generations completed
);

    logic [life_pkg::GRID_CELLS-1:0] world;      // committed model world
    logic [life_pkg::GRID_CELLS-1:0] world_nxt;  // generation under check
    int   wr_cnt;      // strobes since last done
    int   px;          // pixel column within the line
    int   py;          // active line within the frame
    int   de_lines;
    int   h_low;
    int   v_low;
    int   run_frames;  // frames with run high since last done
    logic hsync_q;
    logic vsync_q;
    logic de_q;

    function automatic logic alive_at(input logic [life_pkg::GRID_CELLS-1:0] w,
                                      input int x, input int y);
        if (x < 0 || y < 0 || x >= life_pkg::GRID_W || y >= life_pkg::GRID_H) begin
            return 1'b0;  // no wrap at the edges
        end
        return w[y * life_pkg::GRID_W + x];
    endfunction

    function automatic logic rule_next(input logic [life_pkg::GRID_CELLS-1:0] w,
                                       input int x, input int y);
        int n;
        n = 0;
        for (int i = 0; i < 9; i++) begin
            if (i != 4 && alive_at(w, x + i % 3 - 1, y + i / 3 - 1)) begin
                n++;
            end
        end
        return n == 3 || (n == 2 && alive_at(w, x, y));  // birth on 3, survive on 2 or 3
    endfunction

    task automatic report_fail(input string msg);
        errors = errors + 1;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    initial begin
        errors = 0;
        gens   = 0;
    end

    always @(posedge clk_pix) begin : watch
        int             cx;
        int             cy;
        logic           exp_alive;
        life_pkg::rgb_t exp_rgb;
        if (!rst_n) begin
            world      = life_pkg::SEED;  // DUT reloads the seed as well
            wr_cnt     = 0;
            px         = 0;
            py         = 0;
            de_lines   = 0;
            h_low      = 0;
            v_low      = 0;
            run_frames = 0;
            hsync_q    = 1'b1;
            vsync_q    = 1'b1;
            de_q       = 1'b0;
        end else begin
            if (cell_we) begin
                cx        = wr_cnt % life_pkg::GRID_W;  // raster order expected
                cy        = wr_cnt / life_pkg::GRID_W;
                exp_alive = rule_next(world, cx, cy);
                if (wr_cnt >= life_pkg::GRID_CELLS) begin
                    report_fail("cell write past the last cell");
                end else begin
                    if (int'(cell_wr.x) != cx || int'(cell_wr.y) != cy) begin
                        report_fail($sformatf("cell write to %0d,%0d, expected %0d,%0d",
                                              cell_wr.x, cell_wr.y, cx, cy));
                    end else if (cell_wr.alive !== exp_alive) begin
                        report_fail($sformatf("cell %0d,%0d alive %0b, expected %0b",
                                              cx, cy, cell_wr.alive, exp_alive));
                    end
                    world_nxt[wr_cnt] = exp_alive;  // model value, avoids cascades
                end
                wr_cnt++;
            end else if (wr_cnt > 0 && wr_cnt < life_pkg::GRID_CELLS) begin
                report_fail($sformatf("cell write strobes stopped after %0d", wr_cnt));
                wr_cnt = 0;
            end
            if (done) begin
                if (wr_cnt != life_pkg::GRID_CELLS) begin
                    report_fail($sformatf("done after %0d cell writes", wr_cnt));
                end
                if (run_frames != life_pkg::GEN_FRAMES) begin
                    report_fail($sformatf("done after %0d frames with run high", run_frames));
                end
                world      = world_nxt;  // commit the generation
                wr_cnt     = 0;
                run_frames = 0;
                gens++;
            end
            if (de) begin
                exp_rgb = alive_at(world, px / life_pkg::CELL_SCALE, py / life_pkg::CELL_SCALE)
                          ? life_pkg::ALIVE_RGB : life_pkg::DEAD_RGB;
                if ({red, green, blue} !== exp_rgb) begin
                    report_fail($sformatf("pixel %0d,%0d colour %03h, expected %03h",
                                          px, py, {red, green, blue}, exp_rgb));
                end
                px++;
            end else begin
                if (de_q) begin  // end of an active line
                    if (px != life_pkg::H_ACTIVE) begin
                        report_fail($sformatf("line with %0d de cycles", px));
                    end
                    py++;
                    de_lines++;
                end
                px = 0;
            end
            if (!hsync) begin
                h_low++;
            end else if (!hsync_q) begin
                if (h_low != life_pkg::H_SYNC) begin
                    report_fail($sformatf("hsync low for %0d cycles", h_low));
                end
                h_low = 0;
            end
            if (!vsync && vsync_q) begin  // frame counted here
                if (de_lines != life_pkg::V_ACTIVE) begin
                    report_fail($sformatf("frame with %0d active lines", de_lines));
                end
                de_lines = 0;
                py       = 0;
                if (run) begin
                    run_frames++;
                end
                if (run_frames > life_pkg::GEN_FRAMES) begin
                    report_fail("no generation after enough frames with run high");
                    run_frames = 0;
                end
            end
            if (!vsync) begin
                v_low++;
            end else if (!vsync_q) begin
                if (v_low != life_pkg::V_SYNC * life_pkg::H_TOTAL) begin
                    report_fail($sformatf("vsync low for %0d cycles", v_low));
                end
                v_low = 0;
            end
            hsync_q = hsync;
            vsync_q = vsync;
            de_q    = de;
        end
    end

endmodule

//--- testbench/life_display_props.sv
// concurrent checks bound into life_display and sampled on clk_pix
// start is the internal pacing pulse of the top level
`timescale 1ns/1ps

module life_display_props (
    input logic clk_pix,
    input logic rst_n,
    input logic de,
    input logic hsync,
    input logic vsync,
    input logic start,
    input logic cell_we,
    input logic done
);

    logic after_done;    // done seen and no start since
    int   fail_cnt = 0;  // failed assertions so far

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            after_done <= 1'b0;
        end else if (start) begin
            after_done <= 1'b0;
        end else if (done) begin
            after_done <= 1'b1;
        end
    end

    no_write_in_active: assert property (
        @(posedge clk_pix) disable iff (!rst_n) !(cell_we && de))
        else begin
            $error("cell write strobe during active video");
            fail_cnt++;
        end

    quiet_after_done: assert property (
        @(posedge clk_pix) disable iff (!rst_n) after_done |-> !cell_we)
        else begin
            $error("cell write strobe after done without a new start");
            fail_cnt++;
        end

    sync_idle_in_reset: assert property (
        @(posedge clk_pix) !rst_n |-> hsync && vsync)
        else begin
            $error("sync output active during reset");
            fail_cnt++;
        end

endmodule

bind life_display life_display_props life_display_props_i (
    .clk_pix(clk_pix), .rst_n(rst_n), .de(de), .hsync(hsync), .vsync(vsync),
    .start(start), .cell_we(cell_we), .done(done)
);

//--- testbench/tb_life_display.sv
// drives clock, reset, a random run level and one mid-run reset into life_display
// run only changes at the end of vsync and stays steady at every frame pulse
`timescale 1ns/1ps

module tb_life_display #(
    parameter int RAND_SEED = 26249
);

    localparam int RST_CYCLES     = 16;
    localparam int RUN_FRAMES     = 40;
    localparam int FRAME_CYCLES   = life_pkg::H_TOTAL * life_pkg::V_TOTAL;  // 1200
    localparam int RUN_CYCLES     = RUN_FRAMES * FRAME_CYCLES;              // 48000
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;            // room for resets
    localparam int RST_AT_MIN     = 20000;
    localparam int RST_AT_SPAN    = 10001;  // mid-run reset lands in 20000..30000

    logic               clk_pix = 1'b1;  // first edge is a falling one
    logic               rst_n   = 1'b1;
    logic               run     = 1'b0;
    logic               hsync;
    logic               vsync;
    logic               de;
    life_pkg::chan_t    red;
    life_pkg::chan_t    green;
    life_pkg::chan_t    blue;
    logic               cell_we;
    life_pkg::cell_wr_t cell_wr;
    logic               done;
    int                 checker_errors;
    int                 gens;
    int                 tb_errors   = 0;
    int                 cycles      = 0;
    int                 frames_seen = 0;  // vsync ends seen
    int                 reset_at;
    logic               vsync_q     = 1'b1;

    always #10 clk_pix = ~clk_pix;

    life_display life_display_i (
        .clk_pix, .rst_n, .run, .hsync, .vsync, .de,
        .red, .green, .blue, .cell_we, .cell_wr, .done
    );

    life_checker life_checker_i (
        .clk_pix, .rst_n, .run, .hsync, .vsync, .de,
        .red, .green, .blue, .cell_we, .cell_wr, .done,
        .errors(checker_errors), .gens
    );

    // high three times as often as low
    function automatic logic pick_run_level();
        return ($urandom % 4) != 0;
    endfunction

    task automatic end_run();
        int assert_fails;
        assert_fails = life_display_i.life_display_props_i.fail_cnt;
        $display("errors: checker %0d, testbench %0d, assertions %0d, generations %0d",
                 checker_errors, tb_errors, assert_fails, gens);
        if (checker_errors == 0 && tb_errors == 0 && assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // new run level once per frame at the end of vsync
    always @(negedge clk_pix) begin
        if (vsync && !vsync_q) begin
            run         = pick_run_level();
            frames_seen = frames_seen + 1;
        end
        vsync_q = vsync;
    end

    always @(posedge clk_pix) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
            tb_errors = tb_errors + 1;
            end_run();
        end
    end

    initial begin
        reset_at = RST_AT_MIN + int'($urandom(RAND_SEED) % RST_AT_SPAN);  // seeds the run
        @(negedge clk_pix);
        rst_n = 1'b0;
        run   = pick_run_level();
        repeat (RST_CYCLES) @(negedge clk_pix);
        rst_n = 1'b1;
        while (cycles < reset_at) @(negedge clk_pix);
        rst_n = 1'b0;  // world goes back to the seed
        repeat (RST_CYCLES) @(negedge clk_pix);
        rst_n = 1'b1;
        while (frames_seen < RUN_FRAMES) @(negedge clk_pix);
        if (gens == 0) begin
            $display("no generation was computed during the whole run");
            tb_errors = tb_errors + 1;
        end
        end_run();
    end

endmodule
